// File: logic/cosmic_pkg.sv
// Shared types for the board glue of the vertical-shooter arcade core.
// Player and cabinet controls arrive active high and already decoded.
// Board-side port bytes are active low, as the game board reads them.
// Download addresses are byte addresses of DL_ADDR_W bits.
package cosmic_pkg;

	parameter int DL_ADDR_W = 25;

	// Game selection as set by the platform menu
	typedef enum logic [2:0] {
		game_none         = 3'd0,
		game_space_panic  = 3'd1,
		game_magic_spot   = 3'd2,
		game_cosmic_alien = 3'd3,
		game_devil_zone   = 3'd4,
		game_no_mans_land = 3'd5
	} game_id_e;

	// One player's stick and buttons
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
	} player_ctrl_t;

	// Coin slot and start buttons
	typedef struct packed {
		logic coin;
		logic one_player;
		logic two_players;
	} cabinet_ctrl_t;

	// Port bytes seen by the game CPU, bits active low
	typedef struct packed {
		logic [7:0] in0;
		logic [7:0] in1;
		logic [7:0] in2;
		logic [7:0] dip_a;
	} input_ports_t;

	// One byte of the download stream
	typedef struct packed {
		logic [DL_ADDR_W-1:0] addr;
		logic [7:0]           data;
		logic [7:0]           index;
		logic                 wr;
	} dl_beat_t;

	// One routed write, wr is a single-cycle strobe
	typedef struct packed {
		logic [DL_ADDR_W-1:0] addr;
		logic [7:0]           data;
		logic                 wr;
	} dl_write_t;

endpackage

// File: logic/cpu_clock_enables.sv
// CPU and pixel clock enables derived from clk_sys.
// pix_ena fires every 2nd cycle, cpu_ena every FAST_DIV or SLOW_DIV cycles.
// Both dividers must be even so that fast and slow strobes never sit on
// adjacent cycles when the game changes while running.
module cpu_clock_enables
	import cosmic_pkg::*;
#(
	parameter int FAST_DIV = 4,
	parameter int SLOW_DIV = 6
) (
	input  logic     clk_sys,
	input  logic     reset,
	input  game_id_e game,
	output logic     pix_ena,
	output logic     cpu_ena
);

	localparam int FAST_W = $clog2(FAST_DIV);
	localparam int SLOW_W = $clog2(SLOW_DIV);
	localparam logic [FAST_W-1:0] FAST_LAST = FAST_W'(FAST_DIV - 1);
	localparam logic [SLOW_W-1:0] SLOW_LAST = SLOW_W'(SLOW_DIV - 1);

	logic              pix_cnt;
	logic [FAST_W-1:0] fast_cnt;
	logic [SLOW_W-1:0] slow_cnt;
	logic              fast_stb;
	logic              slow_stb;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pix_cnt  <= 1'b0;
			fast_cnt <= '0;
			slow_cnt <= '0;
			pix_ena  <= 1'b0;
			fast_stb <= 1'b0;
			slow_stb <= 1'b0;
		end else begin
			pix_cnt  <= ~pix_cnt;
			fast_cnt <= (fast_cnt == FAST_LAST) ? '0 : fast_cnt + 1'b1;
			slow_cnt <= (slow_cnt == SLOW_LAST) ? '0 : slow_cnt + 1'b1;
			pix_ena  <= pix_cnt;
			// Strobe on the wrap of each counter
			fast_stb <= (fast_cnt == FAST_LAST);
			slow_stb <= (slow_cnt == SLOW_LAST);
		end
	end

	// Magic Spot and Devil Zone run their CPU at the faster rate
	assign cpu_ena = (game == game_magic_spot || game == game_devil_zone) ? fast_stb : slow_stb;

	a_cpu_ena_single: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_ena |=> !cpu_ena)
		else $error("cpu_ena high in two consecutive cycles");

endmodule

// File: logic/control_port_mux.sv
// Maps decoded controls onto the active-low input ports of each game.
// Purely combinational, outputs follow the inputs in the same cycle.
// Unknown game IDs fall back to the Cosmic Alien layout.
module control_port_mux
	import cosmic_pkg::*;
(
	input  game_id_e      game,
	input  player_ctrl_t  p1,
	input  player_ctrl_t  p2,
	input  cabinet_ctrl_t cab,
	input  logic [15:0]   dip,
	input  logic          vblank,
	input  logic [7:0]    vcount,
	output input_ports_t  ports,
	output logic [7:0]    dip_b
);

	// Space Panic player byte, fire_b sits on top
	function automatic logic [7:0] panic_player(input player_ctrl_t p);
		return {~p.fire_b, 2'b11, ~p.up, ~p.down, ~p.left, ~p.right, ~p.fire_a};
	endfunction

	// Cosmic Alien player byte, left/right and one button only
	function automatic logic [7:0] alien_player(input player_ctrl_t p);
		return {5'b11111, ~p.left, ~p.right, ~p.fire_a};
	endfunction

	input_ports_t panic_ports;
	input_ports_t spot_ports;
	input_ports_t alien_ports;
	logic [7:0]   start_dip;

	// Start buttons share the DIP byte on the later boards
	assign start_dip = {~cab.one_player, ~cab.two_players, dip[5:0]};

	always_comb begin
		panic_ports.in0   = panic_player(p1);
		panic_ports.in1   = panic_player(p2);
		panic_ports.in2   = {1'b1, ~cab.coin, 4'b1111, ~cab.two_players, ~cab.one_player};
		panic_ports.dip_a = dip[7:0];
	end

	always_comb begin
		// Top two bits of in0 carry the bonus DIP switches
		spot_ports.in0   = {dip[15:14], ~p1.right, 3'b111, ~p1.left, 1'b1};
		spot_ports.in1   = {2'b11, ~p2.right, 3'b111, ~p2.left, 1'b1};
		spot_ports.in2   = {~p1.fire_a, ~p2.fire_a, 5'b11111, ~vblank};
		spot_ports.dip_a = start_dip;
	end

	always_comb begin
		alien_ports.in0   = alien_player(p1);
		alien_ports.in1   = alien_player(p2);
		// Raster line is read back through in2
		alien_ports.in2   = {2'b00, vcount[7:2]};
		alien_ports.dip_a = start_dip;
	end

	always_comb begin
		case (game)
			game_space_panic: ports = panic_ports;
			game_magic_spot,
			game_devil_zone,
			game_no_mans_land: ports = spot_ports;
			default: ports = alien_ports;
		endcase
	end

	assign dip_b = dip[15:8];

	always_comb begin
		a_game_valid: assert ($isunknown(game) || game <= game_no_mans_land)
			else $error("invalid game id %0d", game);
	end

endmodule

// File: logic/download_router.sv
// Splits the index-0 download stream into program ROM, sample table and
// wave data writes. Each region gets an address rebased to its own start.
// One register stage, no back-pressure; every beat is taken.
module download_router
	import cosmic_pkg::*;
#(
	parameter int TABLE_BASE_ALIEN = 29696,
	parameter int TABLE_BASE_OTHER = 26656,
	parameter int TABLE_BYTES      = 128
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  game_id_e  game,
	input  dl_beat_t  dl,
	input  logic      downloading,
	output dl_write_t rom_wr,
	output dl_write_t table_wr,
	output dl_write_t wave_wr
);

	logic [DL_ADDR_W-1:0] table_base;
	logic [DL_ADDR_W-1:0] wave_base;
	logic [DL_ADDR_W-1:0] addr_rebased;
	logic                 beat_ok;
	logic                 in_rom;
	logic                 in_table;
	logic [DL_ADDR_W-1:0] addr_q;
	logic [7:0]           data_q;
	logic                 rom_q;
	logic                 table_q;
	logic                 wave_q;

	// Cosmic Alien has a longer program, so its samples start higher
	assign table_base = (game == game_cosmic_alien) ? DL_ADDR_W'(TABLE_BASE_ALIEN)
	                                                : DL_ADDR_W'(TABLE_BASE_OTHER);
	assign wave_base  = table_base + DL_ADDR_W'(TABLE_BYTES);

	assign beat_ok  = dl.wr && (dl.index == 8'd0) && downloading;
	assign in_rom   = dl.addr < table_base;
	assign in_table = !in_rom && (dl.addr < wave_base);

	always_comb begin
		if (in_rom)
			addr_rebased = dl.addr;
		else if (in_table)
			addr_rebased = dl.addr - table_base;
		else
			addr_rebased = dl.addr - wave_base;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_q   <= 1'b0;
			table_q <= 1'b0;
			wave_q  <= 1'b0;
		end else begin
			rom_q   <= beat_ok && in_rom;
			table_q <= beat_ok && in_table;
			wave_q  <= beat_ok && !in_rom && !in_table;
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= addr_rebased;
		data_q <= dl.data;
	end

	// Payload is shared, the strobe tells which region owns it
	assign rom_wr   = '{addr: addr_q, data: data_q, wr: rom_q};
	assign table_wr = '{addr: addr_q, data: data_q, wr: table_q};
	assign wave_wr  = '{addr: addr_q, data: data_q, wr: wave_q};

	a_one_region: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({rom_wr.wr, table_wr.wr, wave_wr.wr}))
		else $error("download beat routed to more than one region");

endmodule

// File: logic/reset_sequencer.sv
// Holds the game board in reset until the first ROM download completes.
// Menu reset and any download in progress also assert core_reset.
// rom_loaded stays set until the next system reset.
module reset_sequencer (
	input  logic clk_sys,
	input  logic reset,
	input  logic downloading,
	input  logic menu_reset,
	output logic core_reset
);

	logic downloading_d;
	logic rom_loaded;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			downloading_d <= 1'b0;
			rom_loaded    <= 1'b0;
			core_reset    <= 1'b1;
		end else begin
			downloading_d <= downloading;
			// End of download marks the ROM as valid
			if (downloading_d && !downloading)
				rom_loaded <= 1'b1;
			core_reset <= menu_reset || downloading || !rom_loaded;
		end
	end

endmodule

// File: logic/cosmic_glue_top.sv
// Board glue between the platform I/O and the game board.
// Clock enables, control ports, download routing and board reset.
// Controls must arrive already decoded and active high.
module cosmic_glue_top
	import cosmic_pkg::*;
#(
	parameter int FAST_DIV         = 4,
	parameter int SLOW_DIV         = 6,
	parameter int TABLE_BASE_ALIEN = 29696,
	parameter int TABLE_BASE_OTHER = 26656,
	parameter int TABLE_BYTES      = 128
) (
	input  logic          clk_sys,
	input  logic          reset,
	input  game_id_e      game,
	input  player_ctrl_t  p1,
	input  player_ctrl_t  p2,
	input  cabinet_ctrl_t cab,
	input  logic [15:0]   dip,
	input  logic          vblank,
	input  logic [7:0]    vcount,
	input  dl_beat_t      dl,
	input  logic          downloading,
	input  logic          menu_reset,
	output logic          pix_ena,
	output logic          cpu_ena,
	output input_ports_t  ports,
	output logic [7:0]    dip_b,
	output dl_write_t     rom_wr,
	output dl_write_t     table_wr,
	output dl_write_t     wave_wr,
	output logic          core_reset
);

	cpu_clock_enables #(
		.FAST_DIV (FAST_DIV),
		.SLOW_DIV (SLOW_DIV)
	) cpu_clock_enables_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.game    (game),
		.pix_ena (pix_ena),
		.cpu_ena (cpu_ena)
	);

	control_port_mux control_port_mux_i (
		.game   (game),
		.p1     (p1),
		.p2     (p2),
		.cab    (cab),
		.dip    (dip),
		.vblank (vblank),
		.vcount (vcount),
		.ports  (ports),
		.dip_b  (dip_b)
	);

	download_router #(
		.TABLE_BASE_ALIEN (TABLE_BASE_ALIEN),
		.TABLE_BASE_OTHER (TABLE_BASE_OTHER),
		.TABLE_BYTES      (TABLE_BYTES)
	) download_router_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.game        (game),
		.dl          (dl),
		.downloading (downloading),
		.rom_wr      (rom_wr),
		.table_wr    (table_wr),
		.wave_wr     (wave_wr)
	);

	reset_sequencer reset_sequencer_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.downloading (downloading),
		.menu_reset  (menu_reset),
		.core_reset  (core_reset)
	);

endmodule

// File: dv/cosmic_glue_tb.sv
// Self-checking testbench for the board glue top level.
// Outputs are sampled on the falling clock edge and inputs change on the rising edge.
// Region bases below must match the parameters handed to the DUT.
// A wait that runs out of cycles counts as an error and the run goes on.
module cosmic_glue_tb;
	import cosmic_pkg::*;

	localparam int TABLE_BASE_ALIEN = 29696;
	localparam int TABLE_BASE_OTHER = 26656;
	localparam int TABLE_BYTES      = 128;
	localparam int TIMEOUT          = 50;

	typedef struct packed {
		game_id_e      game;
		player_ctrl_t  p1;
		player_ctrl_t  p2;
		cabinet_ctrl_t cab;
		logic [15:0]   dip;
		logic          vblank;
		logic [7:0]    vcount;
		input_ports_t  ports;
		logic [7:0]    dip_b;
	} port_row_t;

	logic          clk_sys = 1'b0;
	logic          reset;
	game_id_e      game;
	player_ctrl_t  p1;
	player_ctrl_t  p2;
	cabinet_ctrl_t cab;
	logic [15:0]   dip;
	logic          vblank;
	logic [7:0]    vcount;
	dl_beat_t      dl;
	logic          downloading;
	logic          menu_reset;
	logic          pix_ena;
	logic          cpu_ena;
	input_ports_t  ports;
	logic [7:0]    dip_b;
	dl_write_t     rom_wr;
	dl_write_t     table_wr;
	dl_write_t     wave_wr;
	logic          core_reset;
	int            errors = 0;

	// Expected bytes worked out by hand from the port layouts
	port_row_t port_table [7] = '{
		'{game_space_panic,  6'h21, 6'h00, 3'h4, 16'hA55A, 1'b0, 8'h00, 32'h6FFFBF5A, 8'hA5},
		'{game_magic_spot,   6'h0A, 6'h04, 3'h2, 16'h8137, 1'b1, 8'h55, 32'hBDDF7E77, 8'h81},
		'{game_cosmic_alien, 6'h06, 6'h08, 3'h1, 16'h00FF, 1'b1, 8'hB4, 32'hFCFB2DBF, 8'h00},
		'{game_devil_zone,   6'h00, 6'h00, 3'h0, 16'h4000, 1'b0, 8'hFF, 32'h7FFFFFC0, 8'h40},
		'{game_no_mans_land, 6'h3F, 6'h3F, 3'h7, 16'hFFFF, 1'b1, 8'h00, 32'hDDDD3E3F, 8'hFF},
		'{game_none,         6'h3F, 6'h00, 3'h6, 16'h1234, 1'b0, 8'h0C, 32'hF8FF0374, 8'h12},
		'{game_space_panic,  6'h00, 6'h1E, 3'h3, 16'h00C3, 1'b1, 8'h00, 32'hFFF0FCC3, 8'h00}
	};

	game_id_e route_games [2] = '{game_cosmic_alien, game_magic_spot};

	cosmic_glue_top #(
		.FAST_DIV         (4),
		.SLOW_DIV         (6),
		.TABLE_BASE_ALIEN (TABLE_BASE_ALIEN),
		.TABLE_BASE_OTHER (TABLE_BASE_OTHER),
		.TABLE_BYTES      (TABLE_BYTES)
	) cosmic_glue_top_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.game        (game),
		.p1          (p1),
		.p2          (p2),
		.cab         (cab),
		.dip         (dip),
		.vblank      (vblank),
		.vcount      (vcount),
		.dl          (dl),
		.downloading (downloading),
		.menu_reset  (menu_reset),
		.pix_ena     (pix_ena),
		.cpu_ena     (cpu_ena),
		.ports       (ports),
		.dip_b       (dip_b),
		.rom_wr      (rom_wr),
		.table_wr    (table_wr),
		.wave_wr     (wave_wr),
		.core_reset  (core_reset)
	);

	always #20 clk_sys = ~clk_sys;

	// Bit-level model of the three layouts, unused bits read as one
	function automatic input_ports_t model_ports(input game_id_e g, input player_ctrl_t a,
			input player_ctrl_t b, input cabinet_ctrl_t c, input logic [15:0] d,
			input logic vb, input logic [7:0] vc);
		input_ports_t m;
		m = '1;
		m.dip_a = {~c.one_player, ~c.two_players, d[5:0]};
		case (g)
			game_space_panic: begin
				m.in0 = {~a.fire_b, 2'b11, ~a.up, ~a.down, ~a.left, ~a.right, ~a.fire_a};
				m.in1 = {~b.fire_b, 2'b11, ~b.up, ~b.down, ~b.left, ~b.right, ~b.fire_a};
				m.in2[6] = ~c.coin;
				m.in2[1:0] = {~c.two_players, ~c.one_player};
				m.dip_a = d[7:0];
			end
			game_magic_spot, game_devil_zone, game_no_mans_land: begin
				m.in0[7:6] = d[15:14];
				m.in0[5] = ~a.right;
				m.in0[1] = ~a.left;
				m.in1[5] = ~b.right;
				m.in1[1] = ~b.left;
				m.in2[7:6] = {~a.fire_a, ~b.fire_a};
				m.in2[0] = ~vb;
			end
			default: begin
				m.in0[2:0] = {~a.left, ~a.right, ~a.fire_a};
				m.in1[2:0] = {~b.left, ~b.right, ~b.fire_a};
				m.in2 = {2'b00, vc[7:2]};
			end
		endcase
		return m;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic drive_controls(input game_id_e g, input player_ctrl_t a,
			input player_ctrl_t b, input cabinet_ctrl_t c, input logic [15:0] d,
			input logic vb, input logic [7:0] vc);
		@(posedge clk_sys);
		game   <= g;
		p1     <= a;
		p2     <= b;
		cab    <= c;
		dip    <= d;
		vblank <= vb;
		vcount <= vc;
		@(negedge clk_sys);
	endtask

	// Counts falling edges up to the next strobe on the chosen enable
	task automatic wait_enable(input logic use_cpu, output int cycles);
		logic seen;
		cycles = 0;
		do begin
			@(negedge clk_sys);
			cycles++;
			seen = use_cpu ? cpu_ena : pix_ena;
		end while (seen !== 1'b1 && cycles < TIMEOUT);
		assert (seen === 1'b1) else begin
			$display("No enable strobe seen within %0d cycles", TIMEOUT);
			errors++;
		end
	endtask

	task automatic check_enables(input game_id_e g, input int cpu_gap);
		int gap;
		@(posedge clk_sys);
		game <= g;
		// First strobe only sets the phase after the game change
		wait_enable(1'b1, gap);
		repeat (3) begin
			wait_enable(1'b1, gap);
			check_value("cpu_ena gap", 64'(cpu_gap), 64'(gap));
		end
		wait_enable(1'b0, gap);
		repeat (3) begin
			wait_enable(1'b0, gap);
			check_value("pix_ena gap", 64'(2), 64'(gap));
		end
	endtask

	task automatic wait_core_reset(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk_sys);
			cycles++;
		end while (core_reset !== level && cycles < TIMEOUT);
		assert (core_reset === level) else begin
			$display("core_reset did not reach %0b within %0d cycles", level, TIMEOUT);
			errors++;
		end
	endtask

	// One beat in, then the registered write one edge later
	task automatic route_beat(input logic [DL_ADDR_W-1:0] addr, input logic [7:0] index);
		logic [DL_ADDR_W-1:0] base;
		logic [7:0]           data;
		logic                 hit;
		dl_write_t            want [3];
		dl_write_t            got [3];
		string                names [3];
		names = '{"rom_wr", "table_wr", "wave_wr"};
		base = (game == game_cosmic_alien) ? DL_ADDR_W'(TABLE_BASE_ALIEN)
		                                   : DL_ADDR_W'(TABLE_BASE_OTHER);
		data = 8'($urandom);
		hit  = (index == 8'd0) && downloading;
		want = '{default: '0};
		if (addr < base)
			want[0] = '{addr: addr, data: data, wr: hit};
		else if (addr < base + DL_ADDR_W'(TABLE_BYTES))
			want[1] = '{addr: addr - base, data: data, wr: hit};
		else
			want[2] = '{addr: addr - base - DL_ADDR_W'(TABLE_BYTES), data: data, wr: hit};
		@(posedge clk_sys);
		dl <= '{addr: addr, data: data, index: index, wr: 1'b1};
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(negedge clk_sys);
		got = '{rom_wr, table_wr, wave_wr};
		for (int i = 0; i < 3; i++) begin
			if (want[i].wr)
				check_value(names[i], 64'(want[i]), 64'(got[i]));
			else
				check_value({names[i], ".wr"}, 64'(0), 64'(got[i].wr));
		end
		if (downloading)
			check_value("core_reset", 64'(1), 64'(core_reset));
	endtask

	initial begin
		input_ports_t         expected;
		logic [DL_ADDR_W-1:0] base;
		void'($urandom(32'he5af23f4));
		reset       <= 1'b1;
		game        <= game_none;
		p1          <= '0;
		p2          <= '0;
		cab         <= '0;
		dip         <= '0;
		vblank      <= 1'b0;
		vcount      <= '0;
		dl          <= '0;
		downloading <= 1'b0;
		menu_reset  <= 1'b0;
		repeat (10) begin
			@(negedge clk_sys);
			check_value("pix_ena", 64'(0), 64'(pix_ena));
			check_value("cpu_ena", 64'(0), 64'(cpu_ena));
		end
		@(posedge clk_sys);
		reset <= 1'b0;
		// No ROM yet, so the board stays in reset
		repeat (4) begin
			@(negedge clk_sys);
			check_value("core_reset", 64'(1), 64'(core_reset));
		end

		foreach (port_table[i]) begin
			drive_controls(port_table[i].game, port_table[i].p1, port_table[i].p2,
				port_table[i].cab, port_table[i].dip, port_table[i].vblank,
				port_table[i].vcount);
			check_value("ports", 64'(port_table[i].ports), 64'(ports));
			check_value("dip_b", 64'(port_table[i].dip_b), 64'(dip_b));
		end
		for (int g = 1; g <= 5; g++) begin
			repeat (8) begin
				drive_controls(game_id_e'(3'(g)), 6'($urandom), 6'($urandom), 3'($urandom),
					16'($urandom), 1'($urandom), 8'($urandom));
				expected = model_ports(game, p1, p2, cab, dip, vblank, vcount);
				check_value("ports", 64'(expected), 64'(ports));
				check_value("dip_b", 64'(dip[15:8]), 64'(dip_b));
			end
		end

		for (int g = 0; g <= 5; g++)
			check_enables(game_id_e'(3'(g)), (g == 2 || g == 4) ? 4 : 6);

		@(posedge clk_sys);
		downloading <= 1'b1;
		foreach (route_games[k]) begin
			@(posedge clk_sys);
			game <= route_games[k];
			@(negedge clk_sys);
			base = (game == game_cosmic_alien) ? DL_ADDR_W'(TABLE_BASE_ALIEN)
			                                   : DL_ADDR_W'(TABLE_BASE_OTHER);
			route_beat(base - 1'b1, 8'd0);
			route_beat(base, 8'd0);
			route_beat(base + DL_ADDR_W'(TABLE_BYTES - 1), 8'd0);
			route_beat(base + DL_ADDR_W'(TABLE_BYTES), 8'd0);
			repeat (8)
				route_beat(DL_ADDR_W'($urandom_range(0, 32767)), 8'd0);
			// Other download indexes must be ignored
			repeat (3)
				route_beat(DL_ADDR_W'($urandom_range(0, 32767)), 8'($urandom_range(1, 255)));
		end
		@(posedge clk_sys);
		downloading <= 1'b0;
		wait_core_reset(1'b0);
		repeat (4)
			route_beat(DL_ADDR_W'($urandom_range(0, 32767)), 8'd0);

		@(posedge clk_sys);
		menu_reset <= 1'b1;
		wait_core_reset(1'b1);
		repeat (3) begin
			@(negedge clk_sys);
			check_value("core_reset", 64'(1), 64'(core_reset));
		end
		@(posedge clk_sys);
		menu_reset <= 1'b0;
		wait_core_reset(1'b0);

		// Reload with the ROM already valid, only the download holds reset
		@(posedge clk_sys);
		downloading <= 1'b1;
		wait_core_reset(1'b1);
		route_beat(DL_ADDR_W'($urandom_range(0, 32767)), 8'd0);
		@(posedge clk_sys);
		downloading <= 1'b0;
		wait_core_reset(1'b0);

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: verilog.f
logic/cosmic_pkg.sv
logic/cpu_clock_enables.sv
logic/control_port_mux.sv
logic/download_router.sv
logic/reset_sequencer.sv
logic/cosmic_glue_top.sv
dv/cosmic_glue_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := cosmic_glue_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)
